// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sigma_delta_processor_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/sd_cfg.svh ====
`ifndef SD_CFG_SVH
`define SD_CFG_SVH

// Number of modulator inputs
`define SD_N_CHANNELS 2

// System clocks per modulator clock period
// Must be even, half high and half low
`define SD_CLK_DIV 4

// Modulator bits per output sample
// One of 4, 8, 16, 32 or 64
`define SD_DECIMATION 16

// Third-order CIC accumulator width
`define SD_FILTER_WIDTH (3 * $clog2(`SD_DECIMATION) + 1)

// Output value width
`define SD_SAMPLE_WIDTH 16

// Threshold register address width
`define SD_REG_ADDR_WIDTH 4

`endif

// ==== rtl/sd_pkg.sv ====
`include "sd_cfg.svh"

package sd_pkg;

    // Channel index, never narrower than one bit
    typedef logic [(`SD_N_CHANNELS > 1 ? $clog2(`SD_N_CHANNELS) : 1)-1:0] sd_ch_t;

    // Filter output word
    typedef logic [`SD_SAMPLE_WIDTH-1:0] sd_value_t;

    // Register bus data word
    typedef logic [15:0] sd_word_t;

    // One beat of the sample stream
    typedef struct packed {
        sd_ch_t    channel;
        logic      over_high;
        logic      under_low;
        logic      overrun;
        sd_value_t value;
    } sd_sample_t;

    // Host register access
    // Read data returns one cycle after the read strobe
    typedef struct packed {
        logic                          write;
        logic                          read;
        logic [`SD_REG_ADDR_WIDTH-1:0] addr;
        sd_word_t                      wdata;
    } sd_reg_req_t;

    // Limits of one channel
    typedef struct packed {
        sd_word_t high;
        sd_word_t low;
    } sd_thresholds_t;

endpackage

// ==== rtl/sigma_delta_channel.sv ====
`timescale 1ns/1ps
`include "sd_cfg.svh"

module sigma_delta_channel
    import sd_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,
    input  logic      bit_in,
    input  logic      bit_strobe,
    input  logic      decim_strobe,
    output sd_value_t result,
    output logic      result_valid
);

    localparam int FW = `SD_FILTER_WIDTH;

    //////////////////////////////
    // Integrators
    //////////////////////////////

    logic [FW-1:0] integ1;
    logic [FW-1:0] integ2;
    logic [FW-1:0] integ3;
    logic [FW-1:0] integ1_next;
    logic [FW-1:0] integ2_next;
    logic [FW-1:0] integ3_next;

    // Cascade in one step, each stage adds the new value of the one before
    assign integ1_next = integ1 + FW'(bit_in);
    assign integ2_next = integ2 + integ1_next;
    assign integ3_next = integ3 + integ2_next;

    // Wrapping arithmetic
    // The combs undo any overflow as long as FW covers R cubed
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            integ1 <= '0;
            integ2 <= '0;
            integ3 <= '0;
        end else if (bit_strobe) begin
            integ1 <= integ1_next;
            integ2 <= integ2_next;
            integ3 <= integ3_next;
        end
    end

    //////////////////////////////
    // Combs
    //////////////////////////////

    logic [FW-1:0] comb_dly1;
    logic [FW-1:0] comb_dly2;
    logic [FW-1:0] comb_dly3;
    logic [FW-1:0] comb1;
    logic [FW-1:0] comb2;
    logic [FW-1:0] comb3;

    // decim_strobe always coincides with a bit_strobe
    // Taking integ3_next includes the closing bit of the period
    assign comb1 = integ3_next - comb_dly1;
    assign comb2 = comb1 - comb_dly2;
    assign comb3 = comb2 - comb_dly3;

    // Differential delays of one decimated sample
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            comb_dly1 <= '0;
            comb_dly2 <= '0;
            comb_dly3 <= '0;
        end else if (decim_strobe) begin
            comb_dly1 <= integ3_next;
            comb_dly2 <= comb1;
            comb_dly3 <= comb2;
        end
    end

    // One-cycle pulse after each decimation strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= decim_strobe;
        end
    end

    // Range 0 to R cubed, zero-extended to the sample width
    always_ff @(posedge clock) begin
        if (decim_strobe) begin
            result <= sd_value_t'(comb3);
        end
    end

endmodule

// ==== rtl/sigma_delta_clock_generator.sv ====
`timescale 1ns/1ps
`include "sd_cfg.svh"

module sigma_delta_clock_generator (
    input  logic clock,
    input  logic arst_n,
    input  logic sync,
    output logic clock_out,
    output logic bit_strobe,
    output logic decim_strobe
);

    localparam int HALF = `SD_CLK_DIV / 2;
    localparam int PW   = $clog2(`SD_CLK_DIV);
    localparam int DW   = $clog2(`SD_DECIMATION);

    logic [PW-1:0] prescaler;
    logic [PW-1:0] prescaler_next;
    logic [DW-1:0] decim_count;
    logic          rise_next;

    // Prescaler wraps once per modulator period
    always_comb begin
        if (prescaler == PW'(`SD_CLK_DIV - 1)) begin
            prescaler_next = '0;
        end else begin
            prescaler_next = prescaler + 1'b1;
        end
    end

    // Low half first, rising edge at the midpoint
    assign rise_next = (prescaler_next == PW'(HALF));

    // All outputs registered so the modulator clock is glitch free
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prescaler    <= '0;
            decim_count  <= '0;
            clock_out    <= 1'b0;
            bit_strobe   <= 1'b0;
            decim_strobe <= 1'b0;
        end else if (sync) begin
            // Restart the phase exactly as after reset
            prescaler    <= '0;
            decim_count  <= '0;
            clock_out    <= 1'b0;
            bit_strobe   <= 1'b0;
            decim_strobe <= 1'b0;
        end else begin
            prescaler    <= prescaler_next;
            clock_out    <= (prescaler_next >= PW'(HALF));
            // Strobe marks the cycle in which clock_out rises
            bit_strobe   <= rise_next;
            // Every SD_DECIMATION-th bit closes a decimation period
            decim_strobe <= rise_next && (decim_count == DW'(`SD_DECIMATION - 1));
            if (rise_next) begin
                // Power-of-two ratio, the counter wraps by itself
                decim_count <= decim_count + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/sigma_delta_control.sv ====
`timescale 1ns/1ps
`include "sd_cfg.svh"

module sigma_delta_control
    import sd_pkg::*;
(
    input  logic           clock,
    input  logic           arst_n,
    input  sd_reg_req_t    reg_req,
    output sd_word_t       reg_rdata,
    output logic           reg_rvalid,
    output sd_thresholds_t thresholds [`SD_N_CHANNELS]
);

    localparam int N  = `SD_N_CHANNELS;
    localparam int AW = `SD_REG_ADDR_WIDTH;

    logic [AW-2:0] req_channel;
    logic          req_low;
    sd_word_t      rdata_next;

    // Address 2n is the high limit of channel n, 2n+1 the low limit
    assign req_channel = reg_req.addr[AW-1:1];
    assign req_low     = reg_req.addr[0];

    // Read mux
    // Addresses past the last channel read zero
    always_comb begin
        rdata_next = '0;
        for (int n = 0; n < N; n++) begin
            if (int'(req_channel) == n) begin
                rdata_next = req_low ? thresholds[n].low : thresholds[n].high;
            end
        end
    end

    // Threshold registers
    // Reset opens the window fully so no flag fires
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int n = 0; n < N; n++) begin
                thresholds[n].high <= 16'hFFFF;
                thresholds[n].low  <= '0;
            end
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_req.read;
            if (reg_req.write) begin
                for (int n = 0; n < N; n++) begin
                    if (int'(req_channel) == n) begin
                        if (req_low) begin
                            thresholds[n].low <= reg_req.wdata;
                        end else begin
                            thresholds[n].high <= reg_req.wdata;
                        end
                    end
                end
            end
        end
    end

    // Read data sampled before a same-cycle write lands
    always_ff @(posedge clock) begin
        if (reg_req.read) begin
            reg_rdata <= rdata_next;
        end
    end

endmodule

// ==== rtl/sigma_delta_output_combiner.sv ====
`timescale 1ns/1ps
`include "sd_cfg.svh"

module sigma_delta_output_combiner
    import sd_pkg::*;
(
    input  logic                      clock,
    input  logic                      arst_n,
    input  sd_value_t                 results [`SD_N_CHANNELS],
    input  logic [`SD_N_CHANNELS-1:0] result_valids,
    input  sd_thresholds_t            thresholds [`SD_N_CHANNELS],
    output sd_sample_t                sample_out,
    output logic                      sample_valid,
    input  logic                      sample_ready
);

    localparam int N = `SD_N_CHANNELS;

    sd_sample_t   slot_data [N];
    logic [N-1:0] slot_full;
    logic [N-1:0] slot_take;
    sd_ch_t       rr_ptr;
    sd_ch_t       sel;
    sd_ch_t       sent_channel;
    sd_sample_t   hold_data;
    logic         hold_valid;
    logic         transfer;

    // Round robin, lowest full channel at or after the pointer
    // Walking down lets the nearest one win
    always_comb begin
        int idx;
        sel = rr_ptr;
        for (int k = N - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % N;
            if (slot_full[idx]) begin
                sel = sd_ch_t'(idx);
            end
        end
    end

    // A stalled beat sits in the hold register
    // New results then cannot disturb the stream
    assign sample_valid = hold_valid || (|slot_full);
    assign sample_out   = hold_valid ? hold_data : slot_data[sel];
    assign transfer     = sample_valid && sample_ready;
    assign sent_channel = hold_valid ? hold_data.channel : sel;

    // Shown slot empties on a transfer and also on a stall into hold
    always_comb begin
        for (int n = 0; n < N; n++) begin
            slot_take[n] = !hold_valid && slot_full[n] && (int'(sel) == n);
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            slot_full  <= '0;
            hold_valid <= 1'b0;
            rr_ptr     <= '0;
        end else begin
            // Loading wins over emptying in the same cycle
            for (int n = 0; n < N; n++) begin
                if (result_valids[n]) begin
                    slot_full[n] <= 1'b1;
                end else if (slot_take[n]) begin
                    slot_full[n] <= 1'b0;
                end
            end
            if (transfer) begin
                hold_valid <= 1'b0;
                rr_ptr     <= (int'(sent_channel) == N - 1) ? '0 : sent_channel + 1'b1;
            end else if (sample_valid && !hold_valid) begin
                hold_valid <= 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge clock) begin
        if (sample_valid && !sample_ready && !hold_valid) begin
            hold_data <= slot_data[sel];
        end
        for (int n = 0; n < N; n++) begin
            if (result_valids[n]) begin
                slot_data[n].channel   <= sd_ch_t'(n);
                // Flags against the limits in force at load time
                slot_data[n].over_high <= results[n] > thresholds[n].high;
                slot_data[n].under_low <= results[n] < thresholds[n].low;
                // Unsent sample replaced
                slot_data[n].overrun   <= slot_full[n] && !slot_take[n];
                slot_data[n].value     <= results[n];
            end
        end
    end

endmodule

// ==== rtl/sigma_delta_processor.sv ====
`timescale 1ns/1ps
`include "sd_cfg.svh"

module sigma_delta_processor
    import sd_pkg::*;
(
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic [`SD_N_CHANNELS-1:0] data_in,
    input  logic                      sync,
    output logic                      clock_out,
    input  sd_reg_req_t               reg_req,
    output sd_word_t                  reg_rdata,
    output logic                      reg_rvalid,
    output sd_sample_t                sample_out,
    output logic                      sample_valid,
    input  logic                      sample_ready
);

    // Filter widths exist only for these ratios
    if (`SD_DECIMATION != 4 && `SD_DECIMATION != 8 && `SD_DECIMATION != 16 &&
        `SD_DECIMATION != 32 && `SD_DECIMATION != 64) begin : g_bad_decimation
        $fatal(1, "Decimation ratio %0d is not one of 4, 8, 16, 32, 64", `SD_DECIMATION);
    end

    // Modulator clock needs equal halves
    if (`SD_CLK_DIV < 2 || `SD_CLK_DIV % 2 != 0) begin : g_bad_clk_div
        $fatal(1, "Clock division %0d must be even and at least 2", `SD_CLK_DIV);
    end

    logic                      bit_strobe;
    logic                      decim_strobe;
    sd_value_t                 results [`SD_N_CHANNELS];
    logic [`SD_N_CHANNELS-1:0] result_valids;
    sd_thresholds_t            thresholds [`SD_N_CHANNELS];

    //////////////////////////////
    // Clock and strobes
    //////////////////////////////

    sigma_delta_clock_generator clock_generator_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .sync         (sync),
        .clock_out    (clock_out),
        .bit_strobe   (bit_strobe),
        .decim_strobe (decim_strobe)
    );

    //////////////////////////////
    // Filters
    //////////////////////////////

    // All channels share one decimation phase
    for (genvar n = 0; n < `SD_N_CHANNELS; n++) begin : g_channel
        sigma_delta_channel channel_inst (
            .clock        (clock),
            .arst_n       (arst_n),
            .bit_in       (data_in[n]),
            .bit_strobe   (bit_strobe),
            .decim_strobe (decim_strobe),
            .result       (results[n]),
            .result_valid (result_valids[n])
        );
    end

    //////////////////////////////
    // Registers and output
    //////////////////////////////

    sigma_delta_control control_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .reg_req    (reg_req),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .thresholds (thresholds)
    );

    sigma_delta_output_combiner output_combiner_inst (
        .clock         (clock),
        .arst_n        (arst_n),
        .results       (results),
        .result_valids (result_valids),
        .thresholds    (thresholds),
        .sample_out    (sample_out),
        .sample_valid  (sample_valid),
        .sample_ready  (sample_ready)
    );

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/sd_pkg.sv
rtl/sigma_delta_clock_generator.sv
rtl/sigma_delta_channel.sv
rtl/sigma_delta_control.sv
rtl/sigma_delta_output_combiner.sv
rtl/sigma_delta_processor.sv
tb/sigma_delta_assertions.sv
tb/sigma_delta_processor_tb.sv

// ==== tb/sigma_delta_assertions.sv ====
`timescale 1ns/1ps
`include "sd_cfg.svh"

module sigma_delta_assertions
    import sd_pkg::*;
(
    input logic        clock,
    input logic        arst_n,
    input logic        sync,
    input logic        clock_out,
    input sd_reg_req_t reg_req,
    input logic        reg_rvalid,
    input sd_sample_t  sample_out,
    input logic        sample_valid,
    input logic        sample_ready
);

    localparam int HALF = `SD_CLK_DIV / 2;

    // Stream beat frozen under back-pressure
    assert property (@(posedge clock) disable iff (!arst_n)
        sample_valid && !sample_ready |=> sample_valid && $stable(sample_out))
        else $error("Sample stream changed while stalled");

    // Read answer exactly one cycle after the strobe
    assert property (@(posedge clock) disable iff (!arst_n) reg_req.read |=> reg_rvalid)
        else $error("reg_rvalid missing after read strobe");
    assert property (@(posedge clock) disable iff (!arst_n) !reg_req.read |=> !reg_rvalid)
        else $error("reg_rvalid without read strobe");

    // Each modulator clock level lasts half a division
    assert property (@(posedge clock) disable iff (!arst_n || sync)
        !$stable(clock_out) |=> $stable(clock_out) [*HALF-1] ##1 !$stable(clock_out))
        else $error("clock_out level has wrong length");

endmodule

bind sigma_delta_processor sigma_delta_assertions assertions_inst (
    .clock        (clock),
    .arst_n       (arst_n),
    .sync         (sync),
    .clock_out    (clock_out),
    .reg_req      (reg_req),
    .reg_rvalid   (reg_rvalid),
    .sample_out   (sample_out),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready)
);

// ==== tb/sigma_delta_processor_tb.sv ====
`timescale 1ns/1ps
`include "sd_cfg.svh"

module sigma_delta_processor_tb
    import sd_pkg::*;
();

    localparam int N   = `SD_N_CHANNELS;
    localparam int DIV = `SD_CLK_DIV;
    localparam int DEC = `SD_DECIMATION;
    localparam int FW  = `SD_FILTER_WIDTH;
    // Twice the length of sixty decimation periods
    localparam int LIMIT = 2 * 60 * DIV * DEC;

    logic                          clock = 1'b0;
    logic                          arst_n;
    logic [N-1:0]                  data_in;
    logic                          sync;
    logic                          clock_out;
    sd_reg_req_t                   reg_req;
    sd_word_t                      reg_rdata;
    logic                          reg_rvalid;
    sd_sample_t                    sample_out;
    logic                          sample_valid;
    logic                          sample_ready;

    logic [31:0]    rand_state = 32'h4774;
    // Spare random word for the test sequence, updated once per cycle
    logic [31:0]    rand_word = '0;
    int             ready_mode;
    bit             stall_mode;
    bit             thr_stable;
    sd_thresholds_t shadow_thr [N];
    int             model_phase;
    int             bit_count;
    int             cycles;
    int             error_count;
    int             flags_seen;
    int             prev_ch;
    int             rx_count [N];
    bit             overrun_seen [N];
    sd_value_t      last_val [N];
    logic [FW-1:0]  integ [N][3];
    logic [FW-1:0]  dly [N][3];
    // Expected samples per channel and whether their flags are predictable
    sd_sample_t     exp_q [N][$];
    bit             known_q [N][$];

    sigma_delta_processor sigma_delta_processor_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .data_in      (data_in),
        .sync         (sync),
        .clock_out    (clock_out),
        .reg_req      (reg_req),
        .reg_rdata    (reg_rdata),
        .reg_rvalid   (reg_rvalid),
        .sample_out   (sample_out),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready)
    );

    always #2 clock = ~clock;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic fail_run(string line);
        error_count++;
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_sample(sd_sample_t got, sd_sample_t exp);
        if (got !== exp) begin
            fail_run($sformatf(
                {"ERROR at %0t: sample ch%0d oh%0b ul%0b or%0b v%0d, ",
                 "expected ch%0d oh%0b ul%0b or%0b v%0d"},
                $time, got.channel, got.over_high, got.under_low, got.overrun, got.value,
                exp.channel, exp.over_high, exp.under_low, exp.overrun, exp.value));
        end
    endtask

    task automatic check_rdata(sd_word_t got, sd_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t: reg_rdata %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_level(logic got, logic exp, string what);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    //////////////////////////////
    // Model
    //////////////////////////////

    // Third-order CIC whose combs run once per R modulator bits
    task automatic take_bits(logic [N-1:0] bits);
        logic [FW-1:0] c0;
        logic [FW-1:0] c1;
        logic [FW-1:0] c2;
        sd_sample_t    exp;
        bit_count++;
        for (int n = 0; n < N; n++) begin
            integ[n][0] += FW'(bits[n]);
            integ[n][1] += integ[n][0];
            integ[n][2] += integ[n][1];
            if (bit_count == DEC) begin
                c0 = integ[n][2] - dly[n][0];
                c1 = c0 - dly[n][1];
                c2 = c1 - dly[n][2];
                dly[n][0] = integ[n][2];
                dly[n][1] = c0;
                dly[n][2] = c1;
                exp = '0;
                exp.channel   = sd_ch_t'(n);
                exp.value     = sd_value_t'(c2);
                exp.over_high = exp.value > shadow_thr[n].high;
                exp.under_low = exp.value < shadow_thr[n].low;
                exp_q[n].push_back(exp);
                known_q[n].push_back(thr_stable);
                last_val[n] = exp.value;
            end
        end
        if (bit_count == DEC) begin
            bit_count = 0;
        end
    endtask

    // One stream transfer against the head of the channel's queue
    task automatic receive(sd_sample_t got);
        int         ch;
        int         idx;
        sd_sample_t exp;
        ch = int'(got.channel);
        if (ch >= N || exp_q[ch].size() == 0) begin
            fail_run($sformatf("ERROR at %0t: unexpected sample on channel %0d", $time, ch));
        end
        idx = 0;
        // Overrun delivers the newest value loaded so far
        // Searched from the back of the queue
        if (stall_mode && got.overrun) begin
            idx = exp_q[ch].size() - 1;
            while (idx > 0 && exp_q[ch][idx].value != got.value) begin
                idx--;
            end
            if (idx == 0) begin
                fail_run($sformatf("ERROR at %0t: overrun value %0d matches no newer model value",
                    $time, got.value));
            end
            overrun_seen[ch] = 1'b1;
        end
        repeat (idx) begin
            void'(exp_q[ch].pop_front());
            void'(known_q[ch].pop_front());
        end
        exp = exp_q[ch].pop_front();
        exp.overrun = (idx > 0);
        if (!known_q[ch].pop_front()) begin
            exp.over_high = got.over_high;
            exp.under_low = got.under_low;
        end else if (exp.over_high || exp.under_low) begin
            flags_seen++;
        end
        check_sample(got, exp);
        if (!stall_mode && ch == prev_ch) begin
            fail_run($sformatf("ERROR at %0t: channel %0d sent twice in a row", $time, ch));
        end
        prev_ch = ch;
        rx_count[ch]++;
    endtask

    always @(posedge clock) begin
        if (!arst_n) begin
            model_phase = 0;
            bit_count   = 0;
            for (int n = 0; n < N; n++) begin
                for (int s = 0; s < 3; s++) begin
                    integ[n][s] = '0;
                    dly[n][s]   = '0;
                end
            end
        end else begin
            cycles++;
            if (cycles > LIMIT) begin
                fail_run($sformatf("Timeout: tests not finished after %0d cycles", LIMIT));
            end
            // Low half then high half with the first rise half a period after reset
            check_level(clock_out, (model_phase % DIV) >= DIV / 2, "clock_out");
            if (model_phase % DIV == DIV / 2) begin
                take_bits(data_in);
            end
            if (sync) begin
                model_phase = 0;
                bit_count   = 0;
            end else begin
                model_phase++;
            end
            if (sample_valid && sample_ready) begin
                receive(sample_out);
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    always @(negedge clock) begin
        logic [31:0] r;
        if (arst_n) begin
            r = next_rand();
            data_in      <= r[N-1:0];
            // Mode 0 always ready and mode 1 random while mode 2 stalls
            sample_ready <= (ready_mode == 0) || (ready_mode == 1 && r[7]);
            rand_word    <= next_rand();
        end
    end

    task automatic write_reg(logic [`SD_REG_ADDR_WIDTH-1:0] addr, sd_word_t data);
        @(negedge clock);
        reg_req.write = 1'b1;
        reg_req.addr  = addr;
        reg_req.wdata = data;
        if (int'(addr) / 2 < N) begin
            if (addr[0]) begin
                shadow_thr[int'(addr) / 2].low = data;
            end else begin
                shadow_thr[int'(addr) / 2].high = data;
            end
        end
        @(negedge clock);
        reg_req.write = 1'b0;
    endtask

    task automatic read_check(logic [`SD_REG_ADDR_WIDTH-1:0] addr);
        sd_word_t exp;
        exp = '0;
        if (int'(addr) / 2 < N) begin
            exp = addr[0] ? shadow_thr[int'(addr) / 2].low : shadow_thr[int'(addr) / 2].high;
        end
        reg_req.read = 1'b1;
        reg_req.addr = addr;
        @(negedge clock);
        reg_req.read = 1'b0;
        check_level(reg_rvalid, 1'b1, "reg_rvalid");
        check_rdata(reg_rdata, exp);
    endtask

    task automatic wait_samples(int count);
        int base [N];
        bit done;
        for (int n = 0; n < N; n++) begin
            base[n] = rx_count[n];
        end
        done = 1'b0;
        while (!done) begin
            @(negedge clock);
            done = 1'b1;
            for (int n = 0; n < N; n++) begin
                if (rx_count[n] < base[n] + count) begin
                    done = 1'b0;
                end
            end
        end
    endtask

    task automatic wait_drained();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clock);
            busy = 1'b0;
            for (int n = 0; n < N; n++) begin
                if (exp_q[n].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        arst_n = 1'b0;
        sync = 1'b0;
        data_in = '0;
        reg_req = '0;
        sample_ready = 1'b0;
        ready_mode <= 0;
        stall_mode = 1'b0;
        thr_stable = 1'b1;
        prev_ch = -1;
        for (int n = 0; n < N; n++) begin
            shadow_thr[n].high = 16'hFFFF;
            shadow_thr[n].low  = '0;
        end
        repeat (3) @(negedge clock);
        arst_n = 1'b1;

        // Free-running stream with the window fully open
        wait_samples(8);

        // Register write then read-back where unused addresses read zero
        thr_stable = 1'b0;
        repeat (4) @(negedge clock);
        repeat (24) begin
            r = rand_word;
            write_reg(r[`SD_REG_ADDR_WIDTH-1:0], r[31:16]);
            read_check(r[`SD_REG_ADDR_WIDTH-1:0]);
        end
        for (int n = 0; n < N; n++) begin
            write_reg(2 * n, 16'hFFFF);
            write_reg(2 * n + 1, '0);
        end
        repeat (10) @(negedge clock);
        thr_stable = 1'b1;
        wait_samples(2);

        // Narrow window around recent values so both flags fire
        thr_stable = 1'b0;
        repeat (4) @(negedge clock);
        for (int n = 0; n < N; n++) begin
            write_reg(2 * n, last_val[n]);
            write_reg(2 * n + 1, last_val[n] - 16'd40);
        end
        repeat (10) @(negedge clock);
        thr_stable = 1'b1;
        wait_samples(8);
        if (flags_seen == 0) begin
            fail_run("Threshold flags never fired with limits inside the value range");
        end

        // Random back-pressure
        ready_mode <= 1;
        wait_samples(8);

        // Long stall so every channel gets replaced
        wait_drained();
        ready_mode <= 2;
        stall_mode = 1'b1;
        repeat (3 * DIV * DEC + 8) @(negedge clock);
        ready_mode <= 0;
        wait_drained();
        repeat (4) @(negedge clock);
        for (int n = 0; n < N; n++) begin
            if (!overrun_seen[n]) begin
                fail_run($sformatf("Channel %0d showed no overrun after a long stall", n));
            end
        end
        stall_mode = 1'b0;
        prev_ch = -1;

        // Sync restart at a random phase
        r = rand_word;
        repeat (int'(r % 37) + 1) @(negedge clock);
        sync = 1'b1;
        @(negedge clock);
        sync = 1'b0;
        wait_samples(8);

        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
